// ==== rtl/fpu_defines.svh ====
////////////////////////////////////////////////////////////////////////////
// Binary32 format widths, exponent bias and canonical quiet NaN
// APB address width and register offsets of the multiplier block
////////////////////////////////////////////////////////////////////////////

`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// Binary32 field widths
`define FPU_EXP_W       8
`define FPU_MANT_W      23
`define FPU_BIAS        127

// Canonical quiet NaN, the only NaN the core produces
`define FPU_QNAN        32'h7FC00000

// APB register map
`define FPU_ADDR_W      8
`define FPU_REG_OP_A    8'h00
`define FPU_REG_OP_B    8'h04
`define FPU_REG_CTRL    8'h08
`define FPU_REG_STATUS  8'h0C
`define FPU_REG_RESULT  8'h10

`endif

// ==== rtl/fpu_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Types shared by the multiplier core and its APB register block
// Float word union, operand and pre-normalization structs, flags
////////////////////////////////////////////////////////////////////////////

package fpu_pkg;

`include "fpu_defines.svh"

   // Binary32 word split into its fields
   typedef struct packed {
      logic                   sign;
      logic [`FPU_EXP_W-1:0]  exp;
      logic [`FPU_MANT_W-1:0] mant;
   } fp32_fields_t;

   // Same word seen as raw bus data or as fields
   typedef union packed {
      logic [31:0]  raw;
      fp32_fields_t f;
   } fp32_u;

   // Operand class bits
   typedef struct packed {
      logic zero;
      logic inf;
      logic nan;
   } fp_class_t;

   // Unpacked operand, hidden bit restored
   typedef struct packed {
      logic                 sign;
      logic [`FPU_EXP_W-1:0] exp;
      logic [`FPU_MANT_W:0] mant;
      fp_class_t            cls;
   } fp_operand_t;

   // Product before normalization and rounding
   typedef struct packed {
      logic               sign;
      logic signed [9:0]  exp;
      logic [47:0]        mant;
      logic               result_zero;
      logic               result_inf;
      logic               result_nan;
      logic               invalid;
   } fp_prenorm_t;

   // Exception flags, same order as STATUS bits 7:4
   typedef struct packed {
      logic invalid;
      logic overflow;
      logic underflow;
      logic inexact;
   } fp_flags_t;

endpackage

// ==== rtl/fpu_unpack.sv ====
////////////////////////////////////////////////////////////////////////////
// Operand unpack for the binary32 multiplier
// Field split, hidden bit, denormal flush, zero/inf/NaN classification
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fpu_unpack (
   input  fpu_pkg::fp32_u      op_a,
   input  fpu_pkg::fp32_u      op_b,
   output fpu_pkg::fp_operand_t opnd_a,
   output fpu_pkg::fp_operand_t opnd_b
);

   import fpu_pkg::*;

   // One word to one classified operand
   function automatic fp_operand_t unpack_word(fp32_u w);
      fp_operand_t o;
      logic        exp_zero;
      logic        exp_ones;
      logic        mant_zero;
      exp_zero  = (w.f.exp == '0);
      exp_ones  = &w.f.exp;
      mant_zero = (w.f.mant == '0);
      o.sign    = w.f.sign;
      if (exp_zero) begin
         // Denormals and zeros both become a signed zero
         o.exp  = '0;
         o.mant = '0;
      end else begin
         o.exp  = w.f.exp;
         o.mant = {1'b1, w.f.mant};
      end
      o.cls.zero = exp_zero;
      // All-ones exponent, mantissa picks inf or NaN
      o.cls.inf  = exp_ones & mant_zero;
      o.cls.nan  = exp_ones & ~mant_zero;
      return o;
   endfunction

   assign opnd_a = unpack_word(op_a);
   assign opnd_b = unpack_word(op_b);

endmodule

// ==== rtl/fpu_mult.sv ====
////////////////////////////////////////////////////////////////////////////
// Multiplier datapath ahead of the normalizer
// Sign, signed pre-normalization exponent, 48-bit mantissa product
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "fpu_defines.svh"

module fpu_mult (
   input  fpu_pkg::fp_operand_t opnd_a,
   input  fpu_pkg::fp_operand_t opnd_b,
   output fpu_pkg::fp_prenorm_t prenorm
);

   import fpu_pkg::*;

   localparam logic signed [9:0] exp_bias = 10'(`FPU_BIAS);

   logic any_nan;
   logic inf_times_zero;
   logic any_inf;
   logic any_zero;

   // Class combination
   assign any_nan        = opnd_a.cls.nan | opnd_b.cls.nan;
   assign inf_times_zero = (opnd_a.cls.inf & opnd_b.cls.zero) |
                           (opnd_a.cls.zero & opnd_b.cls.inf);
   assign any_inf        = opnd_a.cls.inf | opnd_b.cls.inf;
   assign any_zero       = opnd_a.cls.zero | opnd_b.cls.zero;

   always_comb begin
      prenorm.sign = opnd_a.sign ^ opnd_b.sign;
      // Exponent sum less bias, two guard bits for over/underflow
      prenorm.exp  = signed'({2'b00, opnd_a.exp}) + signed'({2'b00, opnd_b.exp})
                     - exp_bias;
      // Full 24x24 product
      prenorm.mant = opnd_a.mant * opnd_b.mant;

      // NaN first, then inf, then zero
      prenorm.invalid     = any_nan | inf_times_zero;
      prenorm.result_nan  = any_nan | inf_times_zero;
      prenorm.result_inf  = ~prenorm.result_nan & any_inf;
      prenorm.result_zero = ~prenorm.result_nan & ~any_inf & any_zero;
   end

endmodule

// ==== rtl/fpu_norm.sv ====
////////////////////////////////////////////////////////////////////////////
// Normalizer and round-to-nearest-even stage
// Overflow/underflow handling, special results, result and flag packing
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "fpu_defines.svh"

module fpu_norm (
   input  fpu_pkg::fp_prenorm_t prenorm,
   output fpu_pkg::fp32_u       res,
   output fpu_pkg::fp_flags_t   flags
);

   import fpu_pkg::*;

   localparam logic signed [9:0] exp_max = 10'sd254;
   localparam logic signed [9:0] exp_min = 10'sd1;

   logic signed [9:0] exp_in;
   logic signed [9:0] exp_n;
   logic [47:0]       mant_n;
   logic [23:0]       keep;
   logic              guard;
   logic              sticky;
   logic              round_up;
   logic [24:0]       mant_rnd;
   logic signed [9:0] exp_r;
   logic [22:0]       frac_r;

   assign exp_in = signed'(prenorm.exp);

   ////////////////////////////////////////////////////////////////////////////
   // Normalize
   ////////////////////////////////////////////////////////////////////////////

   // Product in [1,4), at most one right shift needed
   always_comb begin
      if (prenorm.mant[47]) begin
         // Bit shifted out folds into the LSB to keep sticky intact
         mant_n = {1'b0, prenorm.mant[47:2], prenorm.mant[1] | prenorm.mant[0]};
         exp_n  = exp_in + 10'sd1;
      end else begin
         mant_n = prenorm.mant;
         exp_n  = exp_in;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Round to nearest even
   ////////////////////////////////////////////////////////////////////////////

   assign keep     = mant_n[46:23];
   assign guard    = mant_n[22];
   assign sticky   = |mant_n[21:0];
   // Ties go to even LSB
   assign round_up = guard & (sticky | keep[0]);
   assign mant_rnd = {1'b0, keep} + {24'd0, round_up};

   // Carry out of rounding, mantissa becomes 1.0
   assign exp_r  = exp_n + (mant_rnd[24] ? 10'sd1 : 10'sd0);
   assign frac_r = mant_rnd[24] ? mant_rnd[23:1] : mant_rnd[22:0];

   ////////////////////////////////////////////////////////////////////////////
   // Result select and packing
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      res        = '0;
      flags      = '0;
      res.f.sign = prenorm.sign;
      if (prenorm.result_nan) begin
         res.raw       = `FPU_QNAN;
         flags.invalid = prenorm.invalid;
      end else if (prenorm.result_inf) begin
         // Exact infinity, no flags
         res.f.exp = '1;
      end else if (prenorm.result_zero) begin
         res.f.exp  = '0;
         res.f.mant = '0;
      end else if (exp_r > exp_max) begin
         // Overflow to signed infinity
         res.f.exp       = '1;
         flags.overflow  = 1'b1;
         flags.inexact   = 1'b1;
      end else if (exp_r < exp_min) begin
         // Flush to signed zero
         flags.underflow = 1'b1;
         flags.inexact   = 1'b1;
      end else begin
         res.f.exp     = exp_r[7:0];
         res.f.mant    = frac_r;
         flags.inexact = guard | sticky;
      end
   end

endmodule

// ==== rtl/fpu_core.sv ====
////////////////////////////////////////////////////////////////////////////
// Two-stage binary32 multiplier core
// Unpack and multiply, register, normalize and round, register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fpu_core (
   input  logic                clk,
   input  logic                rst,
   input  logic                start,
   input  fpu_pkg::fp32_u      op_a,
   input  fpu_pkg::fp32_u      op_b,
   output logic                done,
   output fpu_pkg::fp32_u      res,
   output fpu_pkg::fp_flags_t  flags
);

   import fpu_pkg::*;

   fp_operand_t opnd_a;
   fp_operand_t opnd_b;
   fp_prenorm_t prenorm_d;
   fp_prenorm_t prenorm_q;
   logic        s1_valid;
   fp32_u       res_d;
   fp_flags_t   flags_d;

   ////////////////////////////////////////////////////////////////////////////
   // Stage 1, unpack and multiply
   ////////////////////////////////////////////////////////////////////////////

   fpu_unpack u_unpack (
      .op_a   (op_a),
      .op_b   (op_b),
      .opnd_a (opnd_a),
      .opnd_b (opnd_b)
   );

   fpu_mult u_mult (
      .opnd_a  (opnd_a),
      .opnd_b  (opnd_b),
      .prenorm (prenorm_d)
   );

   // Valid strobe
   always_ff @(posedge clk) begin
      if (rst) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= start;
      end
   end

   // Pre-normalization data, loaded only with a new operation
   always_ff @(posedge clk) begin
      if (start) begin
         prenorm_q <= prenorm_d;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stage 2, normalize and round
   ////////////////////////////////////////////////////////////////////////////

   fpu_norm u_norm (
      .prenorm (prenorm_q),
      .res     (res_d),
      .flags   (flags_d)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         done <= 1'b0;
      end else begin
         done <= s1_valid;
      end
   end

   // Result registers follow stage 1 valid
   always_ff @(posedge clk) begin
      if (s1_valid) begin
         res   <= res_d;
         flags <= flags_d;
      end
   end

endmodule

// ==== rtl/fpu_apb_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// APB3 register block of the multiplier
// Operand, control, status and result registers, start pulse,
// wait states on early result reads, error on unmapped offsets
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "fpu_defines.svh"

module fpu_apb_regs (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [`FPU_ADDR_W-1:0] paddr,
   input  logic [31:0]            pwdata,
   output logic [31:0]            prdata,
   output logic                   pready,
   output logic                   pslverr,
   output logic                   start,
   output fpu_pkg::fp32_u         op_a,
   output fpu_pkg::fp32_u         op_b,
   input  logic                   done,
   input  fpu_pkg::fp32_u         res,
   input  fpu_pkg::fp_flags_t     flags
);

   import fpu_pkg::*;

   logic        access;
   logic        wr_en;
   logic        sel_op_a;
   logic        sel_op_b;
   logic        sel_ctrl;
   logic        sel_status;
   logic        sel_result;
   logic        addr_ok;
   logic        bad_write;
   logic        result_stall;
   logic        busy;
   logic        ready;
   fp32_u       result_q;
   fp_flags_t   flags_q;
   logic [31:0] status_word;

   ////////////////////////////////////////////////////////////////////////////
   // Decode and handshake
   ////////////////////////////////////////////////////////////////////////////

   assign access     = psel & penable;
   assign sel_op_a   = (paddr == `FPU_REG_OP_A);
   assign sel_op_b   = (paddr == `FPU_REG_OP_B);
   assign sel_ctrl   = (paddr == `FPU_REG_CTRL);
   assign sel_status = (paddr == `FPU_REG_STATUS);
   assign sel_result = (paddr == `FPU_REG_RESULT);
   assign addr_ok    = sel_op_a | sel_op_b | sel_ctrl | sel_status | sel_result;

   // STATUS and RESULT are read only
   assign bad_write  = pwrite & (sel_status | sel_result);

   // Hold a RESULT read until the pending product lands
   assign result_stall = access & ~pwrite & sel_result & busy;
   assign pready       = ~result_stall;
   assign pslverr      = access & pready & (~addr_ok | bad_write);

   // Writes never stall
   assign wr_en = access & pwrite;

   ////////////////////////////////////////////////////////////////////////////
   // Registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         op_a     <= '0;
         op_b     <= '0;
         start    <= 1'b0;
         busy     <= 1'b0;
         ready    <= 1'b0;
         result_q <= '0;
         flags_q  <= '0;
      end else begin
         // Start is a single-cycle pulse
         start <= 1'b0;
         if (wr_en && sel_op_a) begin
            op_a.raw <= pwdata;
         end
         if (wr_en && sel_op_b) begin
            op_b.raw <= pwdata;
         end
         // Go bit, dropped while an operation is pending
         if (wr_en && sel_ctrl && pwdata[0] && !busy) begin
            start <= 1'b1;
            busy  <= 1'b1;
            ready <= 1'b0;
         end
         // Capture core output
         if (done) begin
            result_q <= res;
            flags_q  <= flags;
            busy     <= 1'b0;
            ready    <= 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////////////////////////////////////////

   // Bit 0 busy, bit 1 ready, bits 7:4 flags
   assign status_word = {24'd0, flags_q, 2'b00, ready, busy};

   always_comb begin
      prdata = '0;
      if (psel && !pwrite) begin
         case (paddr)
            `FPU_REG_OP_A:   prdata = op_a.raw;
            `FPU_REG_OP_B:   prdata = op_b.raw;
            `FPU_REG_STATUS: prdata = status_word;
            `FPU_REG_RESULT: prdata = result_q.raw;
            // CTRL reads as zero
            default:         prdata = '0;
         endcase
      end
   end

endmodule

// ==== rtl/fpu_apb_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Top level, APB register block wired to the multiplier core
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "fpu_defines.svh"

module fpu_apb_top (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [`FPU_ADDR_W-1:0] paddr,
   input  logic [31:0]            pwdata,
   output logic [31:0]            prdata,
   output logic                   pready,
   output logic                   pslverr
);

   import fpu_pkg::*;

   // Core side of the register block
   logic      start;
   logic      done;
   fp32_u     op_a;
   fp32_u     op_b;
   fp32_u     res;
   fp_flags_t flags;

   fpu_apb_regs u_regs (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .start   (start),
      .op_a    (op_a),
      .op_b    (op_b),
      .done    (done),
      .res     (res),
      .flags   (flags)
   );

   fpu_core u_core (
      .clk   (clk),
      .rst   (rst),
      .start (start),
      .op_a  (op_a),
      .op_b  (op_b),
      .done  (done),
      .res   (res),
      .flags (flags)
   );

endmodule

// ==== testbench/fpu_tb_tasks.svh ====
////////////////////////////////////////////////////////////////////////////
// APB master tasks, multiply sequence over the bus
// Typed compare tasks for result word, flags and plain bus words
////////////////////////////////////////////////////////////////////////////

`ifndef FPU_TB_TASKS_SVH
`define FPU_TB_TASKS_SVH

   // One APB transfer with a setup phase and an access phase held until pready
   task automatic apb_transfer(input logic wr, input logic [`FPU_ADDR_W-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
      // Setup phase
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      // Access phase
      @(negedge clk);
      penable = 1'b1;
      // Sample a quarter period after the falling edge
      #(CLK_PERIOD/4);
      // Early RESULT reads hold pready low until the product lands
      while (pready !== 1'b1) begin
         @(negedge clk);
         #(CLK_PERIOD/4);
      end
      rdata = prdata;
      err   = pslverr;
      // Transfer completes on this rising edge
      @(posedge clk);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic write_reg(input logic [`FPU_ADDR_W-1:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      logic        err;
      apb_transfer(1'b1, addr, data, unused, err);
      if (err) begin
         abort_run($sformatf("Unexpected slave error on write to offset 0x%02h", addr));
      end
   endtask

   task automatic read_reg(input logic [`FPU_ADDR_W-1:0] addr, output logic [31:0] data);
      logic err;
      apb_transfer(1'b0, addr, 32'd0, data, err);
      if (err) begin
         abort_run($sformatf("Unexpected slave error on read from offset 0x%02h", addr));
      end
   endtask

   // Transfer that must end with pslverr
   task automatic expect_slave_error(input logic wr, input logic [`FPU_ADDR_W-1:0] addr,
                                     input logic [31:0] data);
      logic [31:0] unused;
      logic        err;
      apb_transfer(wr, addr, data, unused, err);
      if (!err) begin
         abort_run($sformatf("No slave error on %s at offset 0x%02h",
                             wr ? "write" : "read", addr));
      end
   endtask

   // Load operands, start, fetch result and flags
   task automatic multiply_via_bus(input fp32_u a, input fp32_u b,
                                   output fp32_u res, output fp_flags_t flg);
      logic [31:0] word;
      write_reg(`FPU_REG_OP_A, a.raw);
      write_reg(`FPU_REG_OP_B, b.raw);
      write_reg(`FPU_REG_CTRL, 32'h1);
      read_reg(`FPU_REG_RESULT, word);
      res.raw = word;
      // Flags sit in STATUS bits 7:4
      read_reg(`FPU_REG_STATUS, word);
      flg = fp_flags_t'(word[7:4]);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_result(input string name, input fp32_u expected, input fp32_u actual);
      if (actual.raw !== expected.raw) begin
         abort_run($sformatf("Error: %s expected 0x%08h actual 0x%08h",
                             name, expected.raw, actual.raw));
      end
   endtask

   task automatic check_flags(input string name, input fp_flags_t expected,
                              input fp_flags_t actual);
      if (actual !== expected) begin
         abort_run($sformatf("Error: %s expected 0x%01h actual 0x%01h",
                             name, 4'(expected), 4'(actual)));
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected) begin
         abort_run($sformatf("Error: %s expected 0x%08h actual 0x%08h",
                             name, expected, actual));
      end
   endtask

`endif

// ==== testbench/fpu_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench top for the APB binary32 multiplier
// Clock, reset, watchdog, stim file vectors, register and random tests
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "fpu_defines.svh"

module fpu_tb;

   import fpu_pkg::*;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 16;
   localparam int CYCLE_BUDGET = 40;
   localparam int MAX_VECTORS  = 64;
   localparam int RAND_COUNT   = 20;
   // Register access tests count as operations in the budget
   localparam int EXTRA_OPS    = 12;

   logic                   clk;
   logic                   rst;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   logic [`FPU_ADDR_W-1:0] paddr;
   logic [31:0]            pwdata;
   logic [31:0]            prdata;
   logic                   pready;
   logic                   pslverr;

   // Four words per vector for a, b, result and flags
   logic [31:0] stim_mem [0:4*MAX_VECTORS-1];
   int          num_vectors;
   logic        stim_loaded;
   integer      seed;

   fpu_apb_top DUT (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   // First failure ends the run
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

`include "fpu_tb_tasks.svh"

   task automatic load_stim();
      for (int i = 0; i < 4*MAX_VECTORS; i++) begin
         // Unused slots get a flags word above 4'hF
         stim_mem[i] = 32'hF000_0000 | 32'(i);
      end
      $readmemh("testbench/fpu_stim.txt", stim_mem);
      num_vectors = 0;
      while (num_vectors < MAX_VECTORS && stim_mem[4*num_vectors+3] <= 32'hF) begin
         num_vectors++;
      end
      if (num_vectors == 0) begin
         abort_run("The stim file holds no vectors");
      end
   endtask

   // Random sign, exponent 64..190 and eleven fraction bits
   function automatic fp32_u random_operand();
      fp32_u       w;
      logic [31:0] r;
      r        = $random(seed);
      w.f.sign = r[31];
      w.f.exp  = 8'd64 + 8'(r[6:0] % 7'd127);
      w.f.mant = {r[22:12], 12'd0};
      return w;
   endfunction

   // Exact product of two short-mantissa operands
   function automatic fp32_u reference_product(fp32_u a, fp32_u b);
      fp32_u       p;
      logic [11:0] ma;
      logic [11:0] mb;
      logic [23:0] prod;
      int          e;
      ma       = {1'b1, a.f.mant[22:12]};
      mb       = {1'b1, b.f.mant[22:12]};
      prod     = 24'(ma) * 24'(mb);
      e        = int'(a.f.exp) + int'(b.f.exp) - `FPU_BIAS;
      p.f.sign = a.f.sign ^ b.f.sign;
      if (prod[23]) begin
         // Product in [2,4)
         p.f.exp  = 8'(e + 1);
         p.f.mant = prod[22:0];
      end else begin
         p.f.exp  = 8'(e);
         p.f.mant = {prod[21:0], 1'b0};
      end
      return p;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Watchdog
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      longint limit_ns;
      wait (stim_loaded === 1'b1);
      limit_ns = longint'((num_vectors + RAND_COUNT + EXTRA_OPS) * CYCLE_BUDGET
                          + RESET_CYCLES) * CLK_PERIOD;
      #(limit_ns);
      $display("Timeout: the tests did not finish within %0d ns", limit_ns);
      $display("ERRORS FOUND");
      $fatal(1, "Watchdog expired");
   end

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      fp32_u       a;
      fp32_u       b;
      fp32_u       res;
      fp32_u       exp_res;
      fp_flags_t   flg;
      logic [31:0] word;
      logic [31:0] last_result;
      seed        = 99767;
      stim_loaded = 1'b0;
      clk         = 1'b0;
      rst         = 1'b1;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      load_stim();
      stim_loaded = 1'b1;
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;

      // Idle bus state out of reset
      if (pready !== 1'b1 || pslverr !== 1'b0) begin
         abort_run("APB outputs are not idle after reset");
      end
      read_reg(`FPU_REG_STATUS, word);
      check_word("STATUS", 32'h0, word);
      read_reg(`FPU_REG_RESULT, word);
      check_word("RESULT", 32'h0, word);
      read_reg(`FPU_REG_OP_A, word);
      check_word("OP_A", 32'h0, word);

      // Ordinary, rounding, edge and special vectors
      for (int i = 0; i < num_vectors; i++) begin
         a.raw       = stim_mem[4*i];
         b.raw       = stim_mem[4*i+1];
         exp_res.raw = stim_mem[4*i+2];
         multiply_via_bus(a, b, res, flg);
         check_result($sformatf("RESULT of vector %0d", i), exp_res, res);
         check_flags($sformatf("STATUS flags of vector %0d", i),
                     fp_flags_t'(stim_mem[4*i+3][3:0]), flg);
      end
      last_result = res.raw;

      // Register access
      write_reg(`FPU_REG_OP_A, 32'h1234_5678);
      write_reg(`FPU_REG_OP_B, 32'hCAFE_F00D);
      read_reg(`FPU_REG_OP_A, word);
      check_word("OP_A", 32'h1234_5678, word);
      read_reg(`FPU_REG_OP_B, word);
      check_word("OP_B", 32'hCAFE_F00D, word);
      read_reg(`FPU_REG_STATUS, word);
      check_word("STATUS busy/ready", 32'h2, {30'd0, word[1:0]});
      expect_slave_error(1'b0, 8'h14, 32'h0);
      expect_slave_error(1'b1, 8'h14, 32'h5A5A_5A5A);
      expect_slave_error(1'b1, `FPU_REG_RESULT, 32'hFFFF_FFFF);
      expect_slave_error(1'b1, `FPU_REG_STATUS, 32'hFFFF_FFFF);
      // Rejected write leaves RESULT alone
      read_reg(`FPU_REG_RESULT, word);
      check_word("RESULT", last_result, word);

      // Random exact products
      for (int n = 0; n < RAND_COUNT; n++) begin
         a       = random_operand();
         b       = random_operand();
         exp_res = reference_product(a, b);
         multiply_via_bus(a, b, res, flg);
         check_result($sformatf("RESULT of random product %0d", n), exp_res, res);
         check_flags($sformatf("STATUS flags of random product %0d", n), '0, flg);
      end

      $display("NO ERRORS");
      $finish;
   end

endmodule

// ==== fpu_apb_top.f ====
+incdir+rtl
+incdir+testbench
rtl/fpu_pkg.sv
rtl/fpu_unpack.sv
rtl/fpu_mult.sv
rtl/fpu_norm.sv
rtl/fpu_core.sv
rtl/fpu_apb_regs.sv
rtl/fpu_apb_top.sv
testbench/fpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Verilator build and run of the APB binary32 multiplier testbench

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
   --top-module fpu_tb -f fpu_apb_top.f -o fpu_sim \
   || { echo "Verilator build failed"; exit 1; }

./obj_dir/fpu_sim > sim.log 2>&1
cat sim.log

# Verdict comes from the simulation log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"
exit 0

// ==== testbench/fpu_stim.txt ====
// Columns: operand a, operand b, expected result, expected flags (all hex)
// Flags digit: bit 3 invalid, bit 2 overflow, bit 1 underflow, bit 0 inexact
3F800000 3F800000 3F800000 0
40000000 40400000 40C00000 0
3FC00000 3FC00000 40100000 0
C0000000 3F000000 BF800000 0
41200000 41200000 42C80000 0
C0400000 C0800000 41400000 0
40490FDB 40000000 40C90FDB 0
3F800001 3F800001 3F800002 1
3F800001 3FC00000 3FC00002 1
3F800003 3FC00000 3FC00004 1
3F842108 3FF80000 40000000 1
7F000000 40000000 7F800000 5
FF000000 40000000 FF800000 5
7F7FFFFF 3F800001 7F800000 5
7F042108 3FF80000 7F800000 5
00800000 3F000000 00000000 3
80800000 3F000000 80000000 3
00800000 3F800000 00800000 0
00842108 3F780000 00800000 1
7FC00000 3F800000 7FC00000 8
3F800000 FF800001 7FC00000 8
7F800000 00000000 7FC00000 8
80000000 FF800000 7FC00000 8
7F800000 C0000000 FF800000 0
FF800000 BF800000 7F800000 0
7F800000 FF800000 FF800000 0
00000000 40400000 00000000 0
80000000 40400000 80000000 0
00000001 7F000000 00000000 0
807FFFFF 3F800000 80000000 0
00400000 C2C80000 80000000 0
